/* memPkg.sv */
/*
 Core array geometry shared by the memory RTL and its testbench.
 Word and address widths follow the 36-bit MB20 word.
*/
package memPkg;

  // Bits in one memory word
  localparam int WordWidth = 36;

  // Word address bits on the SBUS
  localparam int AdrWidth = 18;     // 256K words addressable

  // Default depth of the core array
  // Smaller arrays read zero above the top word
  localparam int MemWords = 2 ** AdrWidth;

endpackage

/* sbusPkg.sv */
/*
 SBUS request constants for the memory phases.
 Sizes of the request mask and word offset within a quadword.
*/
package sbusPkg;

  // Phases A and B of the MB20
  localparam int DefaultPhases = 2;

  // One request bit per word of the quadword
  localparam int RqWidth = 4;

  // Offset of a word inside its quadword
  localparam int OffsetWidth = 2;   // Wraps modulo four

endpackage

/* sbusSlotTimer.sv */
/*
 Generates the two-cycle slot ticks that pace each memory phase.
 A rising start level realigns that phase's slots to the requester.
*/
`timescale 1ns/1ns

module sbusSlotTimer #(
  parameter int NumPhases = 2
) (
  input  logic                 SBUS,
  input  logic                 reset,
  input  logic [NumPhases-1:0] start,     // Request level per phase
  output logic [NumPhases-1:0] slotTick   // Slot boundary per phase
);

  logic [NumPhases-1:0] prevStart;        // Start level seen last cycle
  logic [NumPhases-1:0] slotCnt;          // High in the second half of a slot
  logic [NumPhases-1:0] startRise;

  // Start high now and low last cycle
  assign startRise = start & ~prevStart;

  // A rising start ticks at once, otherwise the counter decides
  assign slotTick = startRise | slotCnt;

  always_ff @(posedge SBUS) begin
    if (reset) begin
      prevStart <= '0;
      slotCnt   <= '0;
    end else begin
      prevStart <= start;
      // After a tick the next cycle is quiet, then the tick comes back
      slotCnt   <= ~slotTick;
    end
  end

endmodule

/* memPhase.sv */
/*
 One MB20 memory phase. Captures a quadword request on a slot tick and
 walks the request mask, one word per slot, driving ackn and dataValid.
*/
`timescale 1ns/1ns

module memPhase (
  input  logic                         SBUS,
  input  logic                         reset,
  input  logic                         slotTick,   // Slot boundary for this phase
  input  logic                         start,      // Request level
  input  logic [memPkg::AdrWidth-1:0]  adr,        // Held stable while start rises
  input  logic [sbusPkg::RqWidth-1:0]  rq,         // Bit 0 is the word at the base offset
  output logic                         ackn,
  output logic                         dataValid,
  output logic [memPkg::AdrWidth-1:0]  readAdr     // Word being returned
);

  // Quadword base bits above the word offset
  localparam int BaseWidth = memPkg::AdrWidth - sbusPkg::OffsetWidth;

  logic [BaseWidth-1:0]            quadBase;       // Upper address of the quadword
  logic [sbusPkg::OffsetWidth-1:0] wordOffset;     // Running offset, wraps mod 4
  logic [sbusPkg::RqWidth-1:0]     toAck;          // Words not yet returned
  logic                            phaseIdle;

  assign phaseIdle = (toAck == '0);

  // Current slot's word is live while the low mask bit is set
  assign ackn      = toAck[0];
  assign dataValid = toAck[0];

  // Offset wraps inside the quadword, base never moves
  assign readAdr = {quadBase, wordOffset};

  // Control state
  always_ff @(posedge SBUS) begin
    if (reset) begin
      toAck      <= '0;
      wordOffset <= '0;
    end else if (slotTick) begin
      if (!phaseIdle) begin
        // Step to the next word of the quadword
        toAck      <= toAck >> 1;
        wordOffset <= wordOffset + 1'b1;
      end else if (start) begin
        // New transfer, start at the requested word
        toAck      <= rq;
        wordOffset <= adr[sbusPkg::OffsetWidth-1:0];
      end
    end
  end

  // Base address, loaded with the mask and never cleared
  always_ff @(posedge SBUS) begin
    if (slotTick && phaseIdle && start) begin
      quadBase <= adr[memPkg::AdrWidth-1:sbusPkg::OffsetWidth];
    end
  end

endmodule

/* coreArray.sv */
/*
 Core word storage. One clocked load port for the maintenance agent
 and one combinational read port per memory phase.
*/
`timescale 1ns/1ns

module coreArray #(
  parameter int NumPhases = 2,
  parameter int MemWords  = 262144
) (
  input  logic                         SBUS,
  input  logic                         loadEn,
  input  logic [memPkg::AdrWidth-1:0]  loadAdr,
  input  logic [memPkg::WordWidth-1:0] loadData,
  input  logic [memPkg::AdrWidth-1:0]  readAdr  [NumPhases],
  output logic [memPkg::WordWidth-1:0] readWord [NumPhases]
);

  logic [memPkg::WordWidth-1:0] mem [MemWords];  // Contents survive reset
  logic                         loadInRange;

  // Writes above the top word are dropped
  assign loadInRange = (32'(loadAdr) < MemWords);

  always_ff @(posedge SBUS) begin
    if (loadEn && loadInRange) begin
      mem[loadAdr] <= loadData;
    end
  end

  // Each phase has its own read port
  for (genvar p = 0; p < NumPhases; p++) begin : readGen
    always_comb begin
      if (32'(readAdr[p]) < MemWords) begin
        readWord[p] = mem[readAdr[p]];
      end else begin
        readWord[p] = '0;                        // Nonexistent memory
      end
    end
  end

endmodule

/* sbusDataReturn.sv */
/*
 Return path to the SBUS data lines. Picks the word of the valid phase,
 adds its parity and reports two phases driving data at once.
*/
`timescale 1ns/1ns

module sbusDataReturn #(
  parameter int NumPhases = 2
) (
  input  logic [NumPhases-1:0]         valid,              // dataValid per phase
  input  logic [memPkg::WordWidth-1:0] readWord [NumPhases],
  output logic [memPkg::WordWidth-1:0] data,
  output logic                         dataPar,
  output logic                         busCollision
);

  // Lowest-numbered valid phase wins, zero when the bus is quiet
  always_comb begin
    data = '0;
    for (int p = NumPhases - 1; p >= 0; p--) begin
      if (valid[p]) begin
        data = readWord[p];     // Lower phases overwrite higher ones
      end
    end
  end

  assign dataPar = ^data;       // XOR over all 36 bits

  // More than one bit set in valid
  assign busCollision = |(valid & (valid - 1'b1));

endmodule

/* mb20Memory.sv */
/*
 Top of the MB20-style core memory on the SBUS. Slot timer, one
 controller per phase, the core array and the data return path.
*/
`timescale 1ns/1ns

module mb20Memory #(
  parameter int NumPhases = sbusPkg::DefaultPhases,
  parameter int MemWords  = memPkg::MemWords
) (
  input  logic                         SBUS,
  input  logic                         reset,

  // Read requests
  input  logic [NumPhases-1:0]         start,
  input  logic [memPkg::AdrWidth-1:0]  adr,
  input  logic [sbusPkg::RqWidth-1:0]  rq,

  // Maintenance load port
  input  logic                         loadEn,
  input  logic [memPkg::AdrWidth-1:0]  loadAdr,
  input  logic [memPkg::WordWidth-1:0] loadData,

  // Returned words
  output logic [NumPhases-1:0]         ackn,
  output logic [NumPhases-1:0]         dataValid,
  output logic [memPkg::WordWidth-1:0] data,
  output logic                         dataPar,
  output logic                         busCollision
);

  logic [NumPhases-1:0]         slotTick;
  logic [memPkg::AdrWidth-1:0]  readAdr  [NumPhases];  // Word address per phase
  logic [memPkg::WordWidth-1:0] readWord [NumPhases];  // Array output per phase

  // Slots stand in for the real negedge and posedge phase clocks
  sbusSlotTimer #(
    .NumPhases(NumPhases)
  ) slotTimer (
    .SBUS    (SBUS),
    .reset   (reset),
    .start   (start),
    .slotTick(slotTick)
  );

  // Identical controllers, phase A is index 0
  for (genvar p = 0; p < NumPhases; p++) begin : phaseGen
    memPhase phase (
      .SBUS     (SBUS),
      .reset    (reset),
      .slotTick (slotTick[p]),
      .start    (start[p]),
      .adr      (adr),         // Shared request lines
      .rq       (rq),
      .ackn     (ackn[p]),
      .dataValid(dataValid[p]),
      .readAdr  (readAdr[p])
    );
  end

  coreArray #(
    .NumPhases(NumPhases),
    .MemWords (MemWords)
  ) core (
    .SBUS    (SBUS),
    .loadEn  (loadEn),
    .loadAdr (loadAdr),
    .loadData(loadData),
    .readAdr (readAdr),
    .readWord(readWord)
  );

  sbusDataReturn #(
    .NumPhases(NumPhases)
  ) dataReturn (
    .valid       (dataValid),
    .readWord    (readWord),
    .data        (data),
    .dataPar     (dataPar),
    .busCollision(busCollision)
  );

endmodule

/* tbMb20Memory.sv */
/*
 Testbench for the MB20 core memory. Replays the golden file through the DUT,
 checking words, parity, acknowledges and collisions cycle by cycle.
*/
`timescale 1ns/1ns

module tbMb20Memory;

  localparam int NumPhases = sbusPkg::DefaultPhases;
  localparam int Cycles    = 64;     // Longest schedule of one record
  localparam int Ww        = memPkg::WordWidth;

  logic                         SBUS;
  logic                         reset;
  logic [NumPhases-1:0]         start;
  logic [memPkg::AdrWidth-1:0]  adr;
  logic [sbusPkg::RqWidth-1:0]  rq;
  logic                         loadEn;
  logic [memPkg::AdrWidth-1:0]  loadAdr;
  logic [Ww-1:0]                loadData;
  logic [NumPhases-1:0]         ackn;
  logic [NumPhases-1:0]         dataValid;
  logic [Ww-1:0]                data;
  logic                         dataPar;
  logic                         busCollision;

  // Per-cycle schedule of one record, offset 0 is the first negedge
  logic [NumPhases-1:0]         expV     [Cycles];
  logic [Ww-1:0]                expW     [Cycles][NumPhases];
  logic [NumPhases-1:0]         startSch [Cycles];
  logic [memPkg::AdrWidth-1:0]  adrSch   [Cycles];
  logic [sbusPkg::RqWidth-1:0]  rqSch    [Cycles];
  int                           schedLen;

  logic [Ww-1:0] model [int];         // Words written through the load port
  string         lines [$];           // Golden file, one entry per line
  int            lineCount = 0;
  bit            linesRead = 0;
  int            errCount  = 0;
  logic [31:0]   rndState  = 32'he2e7;

  mb20Memory DUT (
    .SBUS(SBUS), .reset(reset), .start(start), .adr(adr), .rq(rq),
    .loadEn(loadEn), .loadAdr(loadAdr), .loadData(loadData),
    .ackn(ackn), .dataValid(dataValid), .data(data), .dataPar(dataPar),
    .busCollision(busCollision)
  );

  initial SBUS = 1'b0;
  always #20 SBUS = ~SBUS;            // 40 ns period

  task automatic stopRun();
    errCount++;
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    stopRun();
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic readGolden();
    int    fd;
    int    status;
    string line;
    fd = $fopen("mb20Golden.dat", "r");
    assert (fd != 0) else begin
      $display("Could not open the golden file mb20Golden.dat");
      stopRun();
    end
    while (!$feof(fd)) begin
      status = $fgets(line, fd);
      if (status > 0) lines.push_back(line);
    end
    $fclose(fd);
    lineCount = lines.size();
    linesRead = 1;                    // Lets the watchdog arm
  endtask

  // Word i of the request sits at (offset + i) mod 4 inside the quadword
  task automatic modelWords(input logic [17:0] a, input logic [3:0] m,
                            output logic [4*Ww-1:0] w);
    int          n;
    logic [17:0] wa;
    w = '0;
    n = 0;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) begin
        wa = {a[17:2], 2'(a[1:0] + i)};
        assert (model.exists(int'(wa))) else begin
          $display("Request reads address %h that was never loaded", wa);
          stopRun();
        end
        w[n*Ww +: Ww] = model[int'(wa)];
        n++;
      end
    end
  endtask

  // Golden words must agree with the model before the DUT sees them
  task automatic verifyGolden(input int lineNo, input logic [17:0] a,
                              input logic [3:0] m, input logic [4*Ww-1:0] gold);
    logic [4*Ww-1:0] want;
    modelWords(a, m, want);
    assert (want === gold) else begin
      $display("Golden file line %0d does not agree with its own loads", lineNo);
      stopRun();
    end
  endtask

  task automatic clearSchedule();
    for (int c = 0; c < Cycles; c++) begin
      expV[c]     = '0;
      startSch[c] = '0;
      adrSch[c]   = '0;
      rqSch[c]    = '0;
      for (int p = 0; p < NumPhases; p++) expW[c][p] = '0;
    end
    schedLen = 0;
  endtask

  // Load tick at offset t, bit i presented at t+1+2i and t+2+2i
  task automatic scheduleRequest(input int phase, input int t0, input logic [17:0] a,
                                 input logic [3:0] m, input logic [4*Ww-1:0] w,
                                 input int transfers);
    int h;
    int t;
    int n;
    h = 0;
    t = t0;
    for (int i = 0; i < 4; i++) if (m[i]) h = i;
    assert (t0 + transfers * 2 * (h + 2) + 5 < Cycles) else begin
      $display("Golden record needs a longer schedule than the testbench holds");
      stopRun();
    end
    for (int k = 0; k < transfers; k++) begin
      n = 0;
      for (int i = 0; i < 4; i++) begin
        if (m[i]) begin
          expV[t+1+2*i][phase] = 1'b1;
          expV[t+2+2*i][phase] = 1'b1;
          expW[t+1+2*i][phase] = w[n*Ww +: Ww];
          expW[t+2+2*i][phase] = w[n*Ww +: Ww];
          n++;
        end
      end
      if (k < transfers - 1) t = t + 2 * (h + 2);   // Next load after mask empties
    end
    for (int c = t0; c <= t; c++) begin   // Start held up to the last load tick
      startSch[c][phase] = 1'b1;
      adrSch[c]          = a;
      rqSch[c]           = m;
    end
    if (t + 2 * h + 5 > schedLen) schedLen = t + 2 * h + 5;
  endtask

  task automatic checkCycle(input int c);
    logic [Ww-1:0] want;
    bit            found;
    want  = '0;
    found = 1'b0;
    for (int p = 0; p < NumPhases; p++) begin
      if (expV[c][p] && !found) begin
        want  = expW[c][p];                       // First valid phase owns the bus
        found = 1'b1;
      end
    end
    assert (dataValid === expV[c])
      else mismatch($sformatf("dataValid %b, expected %b", dataValid, expV[c]));
    assert (ackn === expV[c])
      else mismatch($sformatf("ackn %b, expected %b", ackn, expV[c]));
    assert (busCollision === ($countones(expV[c]) > 1))
      else mismatch($sformatf("busCollision %b with valid %b", busCollision, expV[c]));
    assert (data === want)
      else mismatch($sformatf("data %h, expected %h", data, want));
    assert (dataPar === ($countones(want) % 2 == 1))   // Odd count of ones
      else mismatch($sformatf("dataPar %b for data %h", dataPar, data));
  endtask

  // Check what the last edge produced, then drive the next inputs
  task automatic runSchedule();
    for (int c = 0; c < schedLen; c++) begin
      @(negedge SBUS);
      checkCycle(c);
      loadEn = 1'b0;
      start  = startSch[c];
      adr    = adrSch[c];
      rq     = rqSch[c];
    end
  endtask

  task automatic runIdle(input int n);
    clearSchedule();
    schedLen = n;
    runSchedule();
  endtask

  task automatic loadWord(input logic [17:0] a, input logic [Ww-1:0] w);
    @(negedge SBUS);
    loadEn   = 1'b1;
    loadAdr  = a;
    loadData = w;
    model[int'(a)] = w;
  endtask

  // Watchdog sized from the golden file length
  initial begin
    wait (linesRead);
    #(longint'(lineCount) * 40 * 40);
    $display("Watchdog expired, the run did not finish in time");
    stopRun();
  end

  initial begin : mainFlow
    string           tag;
    int              cnt;
    logic [Ww-1:0]   fld [13];
    logic [4*Ww-1:0] words;
    logic [17:0]     base;
    reset = 1'b1;
    start = '0;
    adr = '0;
    rq = '0;
    loadEn = 1'b0;
    loadAdr = '0;
    loadData = '0;
    readGolden();
    repeat (5) @(negedge SBUS);
    reset = 1'b0;
    runIdle(4);                       // Quiet bus after reset

    // First pass, all loads
    foreach (lines[i]) begin
      cnt = $sscanf(lines[i], "%s %h %h", tag, fld[0], fld[1]);
      if (cnt == 3 && tag == "L") loadWord(fld[0][17:0], fld[1]);
    end
    runIdle(2);

    // Second pass, requests
    foreach (lines[i]) begin
      cnt = $sscanf(lines[i], "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                    fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
      if (cnt < 1 || tag.getc(0) == "#" || tag == "L") continue;
      clearSchedule();
      if (tag == "R" && cnt == 8) begin
        words = {fld[6], fld[5], fld[4], fld[3]};
        verifyGolden(i + 1, fld[1][17:0], fld[2][3:0], words);
        scheduleRequest(int'(fld[0]), 1, fld[1][17:0], fld[2][3:0], words, 1);
      end else if (tag == "H" && cnt == 9) begin
        words = {fld[7], fld[6], fld[5], fld[4]};
        verifyGolden(i + 1, fld[1][17:0], fld[2][3:0], words);
        scheduleRequest(int'(fld[0]), 1, fld[1][17:0], fld[2][3:0], words,
                        int'(fld[3]));
      end else if (tag == "C" && cnt == 14) begin
        words = {fld[8], fld[7], fld[6], fld[5]};
        verifyGolden(i + 1, fld[0][17:0], fld[1][3:0], words);
        scheduleRequest(0, 1, fld[0][17:0], fld[1][3:0], words, 1);
        words = {fld[12], fld[11], fld[10], fld[9]};
        verifyGolden(i + 1, fld[2][17:0], fld[3][3:0], words);
        scheduleRequest(1, 1 + int'(fld[4]), fld[2][17:0], fld[3][3:0], words, 1);
      end else if (tag == "I" && cnt == 2) begin
        schedLen = int'(fld[0]);
      end else begin
        $display("Golden file line %0d is not a valid record", i + 1);
        stopRun();
      end
      runSchedule();
    end

    // Random quadwords loaded right before their readback
    for (int r = 0; r < 3; r++) begin
      rndState = xorshift(rndState);
      base = rndState[17:0] & 18'h3fffc;
      for (int k = 0; k < 4; k++) begin
        rndState = xorshift(rndState);
        loadWord(base | 18'(k), {rndState[3:0], xorshift(rndState)});
      end
      rndState = xorshift(rndState);
      modelWords(base | 18'(rndState[1:0]), 4'hf, words);
      clearSchedule();
      scheduleRequest(r % NumPhases, 0, base | 18'(rndState[1:0]), 4'hf, words, 1);
      runSchedule();
    end

    if (errCount == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stopRun();
    end
  end

endmodule

/* mb20Golden.dat */
# L adr word | R phase adr mask w0 w1 w2 w3 | H phase adr mask transfers w0..w3
# C adrA rqA adrB rqB delayB wA0..wA3 wB0..wB3 | I cycles  (hex, unused words 0)
# Quadword at 00100
L 00100 000000001
L 00101 000000003
L 00102 123456789
L 00103 FFFFFFFFF
# Quadword at 00204, mixed parity
L 00204 0ABCDEF01
L 00205 800000000
L 00206 555555555
L 00207 7FFFFFFFF
# Top quadword of the array
L 3FFFC 111111111
L 3FFFD 222222222
L 3FFFE 333333333
L 3FFFF 444444444
# Quadword at 01230
L 01230 0DEADBEEF
L 01231 0CAFEF00D
L 01232 765432100
L 01233 000000ACE
# Full mask from offset 2, wraps to 0 and 1
R 0 00102 f 123456789 FFFFFFFFF 000000001 000000003
I 2
# Sparse masks
R 0 00205 a 555555555 0ABCDEF01 000000000 000000000
R 1 3FFFF 4 222222222 000000000 000000000 000000000
R 1 00204 9 0ABCDEF01 7FFFFFFFF 000000000 000000000
I 3
# Phase B full quadword from offset 1
R 1 01231 f 0CAFEF00D 765432100 000000ACE 0DEADBEEF
# Parity with odd and even bit counts
R 0 00207 1 7FFFFFFFF 000000000 000000000 000000000
R 0 00103 1 FFFFFFFFF 000000000 000000000 000000000
R 1 00100 3 000000001 000000003 000000000 000000000
R 0 3FFFC 1 111111111 000000000 000000000 000000000
I 4
# Phases A and B interleaved without overlap
C 00100 5 00204 5 2 000000001 123456789 000000000 000000000 0ABCDEF01 555555555 000000000 000000000
C 3FFFC 1 01230 1 2 111111111 000000000 000000000 000000000 0DEADBEEF 000000000 000000000 000000000
I 2
# Overlapping phases raise busCollision, phase A drives data
C 00103 f 3FFFE 3 1 FFFFFFFFF 000000001 000000003 123456789 333333333 444444444 000000000 000000000
C 01232 3 01230 1 2 765432100 000000ACE 000000000 000000000 0DEADBEEF 000000000 000000000 000000000
I 3
# Start held high across back-to-back transfers
H 0 00101 f 3 000000003 123456789 FFFFFFFFF 000000001
H 1 00206 6 2 7FFFFFFFF 0ABCDEF01 000000000 000000000
I 2
R 0 01233 f 000000ACE 0DEADBEEF 0CAFEF00D 765432100
I 2

/* vlog.f */
memPkg.sv
sbusPkg.sv
sbusSlotTimer.sv
memPhase.sv
coreArray.sv
sbusDataReturn.sv
mb20Memory.sv
tbMb20Memory.sv
